// File: sd_init_pkg.sv
/*
 * sd card init shared definitions
 * byte and pin types, sequencer states, the CMD0 frame,
 * SD protocol constants and debug characters
 */
package sd_init_pkg;

    // ==============================
    // types
    // ==============================
    typedef logic [7:0] sd_byte_t;

    // card-facing pins
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic cs_n;
    } spi_pins_t;

    // one debug character request
    typedef struct packed {
        logic     valid;
        sd_byte_t ch;
    } debug_char_t;

    typedef enum logic [3:0] {
        startup,
        print_banner,
        power_on_clk,
        assert_cs,
        send_cmd,
        poll_r1,
        print_result,
        done_ok,
        done_error
    } seq_state_e;

    // ==============================
    // SD protocol
    // ==============================
    localparam int CMD_LEN = 6;
    // CMD0 with zero argument, crc 0x95 plus end bit
    localparam sd_byte_t [0:CMD_LEN-1] CMD0_FRAME = {8'h40, 8'h00, 8'h00, 8'h00, 8'h00, 8'h95};
    // 10 bytes give 80 clocks, card wants at least 74
    localparam int       POWER_ON_BYTES = 10;
    localparam sd_byte_t FILL_BYTE      = 8'hFF;
    localparam sd_byte_t R1_IDLE        = 8'h01;
    localparam int       R1_POLL_LIMIT  = 100;

    // ==============================
    // debug characters
    // ==============================
    localparam int BANNER_LEN = 3;
    localparam sd_byte_t [0:BANNER_LEN-1] BANNER = {"S", "D", " "};
    localparam sd_byte_t CHAR_OK      = "1";
    localparam sd_byte_t CHAR_ERROR   = "E";
    localparam sd_byte_t CHAR_TIMEOUT = "T";

endpackage

// File: spi_byte_master.sv
/*
 * SPI mode-0 byte master
 * divides CLOCK_50 down to sclk, shifts one byte out on mosi
 * and one byte in from miso, MSB first
 */
`timescale 1ns/100ps

module spi_byte_master #(
    parameter int SCLK_HALF_CYCLES = 125
) (
    input  logic                  CLOCK_50,
    input  logic                  reset_n_sync,
    input  logic                  start,
    input  sd_init_pkg::sd_byte_t tx_byte,
    output logic                  ready,
    output logic                  done,
    output sd_init_pkg::sd_byte_t rx_byte,
    output logic                  sclk,
    output logic                  mosi,
    input  logic                  miso
);

    localparam int CNT_W = $clog2(SCLK_HALF_CYCLES + 1);

    logic                  busy;
    logic [CNT_W-1:0]      half_cnt;
    // 16 sclk toggles per byte
    logic [3:0]            edge_cnt;
    sd_init_pkg::sd_byte_t tx_sh;
    sd_init_pkg::sd_byte_t rx_sh;
    logic                  tick;

    // sclk toggles when the half-period counter runs out
    assign tick = busy && (half_cnt == '0);

    always_ff @(posedge CLOCK_50 or negedge reset_n_sync) begin
        if (!reset_n_sync) begin
            busy     <= 1'b0;
            half_cnt <= '0;
            edge_cnt <= '0;
            sclk     <= 1'b0;
            tx_sh    <= 8'hFF;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy     <= 1'b1;
                // first half short by one, keeps done at 16 half periods
                half_cnt <= CNT_W'(SCLK_HALF_CYCLES - 2);
                edge_cnt <= '0;
                tx_sh    <= tx_byte;
            end else if (tick) begin
                half_cnt <= CNT_W'(SCLK_HALF_CYCLES - 1);
                sclk     <= ~sclk;
                edge_cnt <= edge_cnt + 4'd1;
                // falling edge, next bit onto mosi, ones fill behind
                if (sclk) begin
                    tx_sh <= {tx_sh[6:0], 1'b1};
                end
                // last falling edge ends the byte
                if (edge_cnt == 4'd15) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (busy) begin
                half_cnt <= half_cnt - 1'b1;
            end
        end
    end

    // rising edge, capture miso
    always_ff @(posedge CLOCK_50) begin
        if (tick && !sclk) begin
            rx_sh <= {rx_sh[6:0], miso};
        end
    end

    assign ready   = !busy;
    assign rx_byte = rx_sh;
    // idles high since the shifter refills with ones
    assign mosi    = tx_sh[7];

endmodule

// File: sd_cmd0_sequencer.sv
/*
 * SD card CMD0 sequencer
 * startup wait, banner, power-on clocks, CMD0 frame and R1 poll,
 * then one result character and chip select release
 */
`timescale 1ns/100ps

module sd_cmd0_sequencer #(
    parameter int STARTUP_CYCLES = 500000
) (
    input  logic                     CLOCK_50,
    input  logic                     reset_n_sync,
    output logic                     spi_start,
    output sd_init_pkg::sd_byte_t    spi_tx,
    input  logic                     spi_ready,
    input  logic                     spi_done,
    input  sd_init_pkg::sd_byte_t    spi_rx,
    output logic                     cs_n,
    output sd_init_pkg::debug_char_t dbg,
    input  logic                     dbg_busy,
    output logic                     status_led
);

    // shared counter must hold the startup delay and the poll count
    localparam int CNT_MAX = (STARTUP_CYCLES > sd_init_pkg::R1_POLL_LIMIT) ?
                             STARTUP_CYCLES : sd_init_pkg::R1_POLL_LIMIT;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    sd_init_pkg::seq_state_e state;
    logic [CNT_W-1:0]        cnt;
    sd_init_pkg::sd_byte_t   result_char;
    logic                    result_ok;
    logic                    spi_idle;
    logic                    dbg_free;

    // no byte in flight, no start just issued, no done this cycle
    assign spi_idle = spi_ready && !spi_start && !spi_done;
    // busy only rises the cycle after valid
    assign dbg_free = !dbg_busy && !dbg.valid;

    always_ff @(posedge CLOCK_50 or negedge reset_n_sync) begin
        if (!reset_n_sync) begin
            state       <= sd_init_pkg::startup;
            cnt         <= '0;
            spi_start   <= 1'b0;
            spi_tx      <= sd_init_pkg::FILL_BYTE;
            cs_n        <= 1'b1;
            dbg         <= '0;
            result_char <= sd_init_pkg::CHAR_TIMEOUT;
            result_ok   <= 1'b0;
        end else begin
            // strobes default off
            spi_start <= 1'b0;
            dbg.valid <= 1'b0;

            case (state)
                // ==============================
                // power-up wait and banner
                // ==============================
                sd_init_pkg::startup: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(STARTUP_CYCLES - 1)) begin
                        cnt   <= '0;
                        state <= sd_init_pkg::print_banner;
                    end
                end
                sd_init_pkg::print_banner: begin
                    // hold here while the transmitter is busy
                    if (dbg_free) begin
                        dbg.valid <= 1'b1;
                        dbg.ch    <= sd_init_pkg::BANNER[cnt[1:0]];
                        cnt       <= cnt + 1'b1;
                        if (cnt == CNT_W'(sd_init_pkg::BANNER_LEN - 1)) begin
                            cnt   <= '0;
                            state <= sd_init_pkg::power_on_clk;
                        end
                    end
                end

                // ==============================
                // SPI traffic
                // ==============================
                sd_init_pkg::power_on_clk: begin
                    // fill bytes with cs_n still high
                    if (spi_idle) begin
                        spi_start <= 1'b1;
                        spi_tx    <= sd_init_pkg::FILL_BYTE;
                    end
                    if (spi_done) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == CNT_W'(sd_init_pkg::POWER_ON_BYTES - 1)) begin
                            cnt   <= '0;
                            state <= sd_init_pkg::assert_cs;
                        end
                    end
                end
                sd_init_pkg::assert_cs: begin
                    cs_n  <= 1'b0;
                    state <= sd_init_pkg::send_cmd;
                end
                sd_init_pkg::send_cmd: begin
                    if (spi_idle) begin
                        spi_start <= 1'b1;
                        spi_tx    <= sd_init_pkg::CMD0_FRAME[cnt[2:0]];
                    end
                    // card reply during the frame is ignored
                    if (spi_done) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == CNT_W'(sd_init_pkg::CMD_LEN - 1)) begin
                            cnt   <= '0;
                            state <= sd_init_pkg::poll_r1;
                        end
                    end
                end
                sd_init_pkg::poll_r1: begin
                    if (spi_idle) begin
                        spi_start <= 1'b1;
                        spi_tx    <= sd_init_pkg::FILL_BYTE;
                    end
                    // classify the byte that just arrived
                    if (spi_done) begin
                        if (spi_rx != sd_init_pkg::FILL_BYTE) begin
                            result_ok   <= (spi_rx == sd_init_pkg::R1_IDLE);
                            result_char <= (spi_rx == sd_init_pkg::R1_IDLE) ?
                                           sd_init_pkg::CHAR_OK : sd_init_pkg::CHAR_ERROR;
                            state       <= sd_init_pkg::print_result;
                        end else if (cnt == CNT_W'(sd_init_pkg::R1_POLL_LIMIT - 1)) begin
                            // card never answered
                            result_ok   <= 1'b0;
                            result_char <= sd_init_pkg::CHAR_TIMEOUT;
                            state       <= sd_init_pkg::print_result;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end

                // ==============================
                // result and release
                // ==============================
                sd_init_pkg::print_result: begin
                    if (dbg_free) begin
                        dbg.valid <= 1'b1;
                        dbg.ch    <= result_char;
                        state     <= result_ok ? sd_init_pkg::done_ok : sd_init_pkg::done_error;
                    end
                end
                sd_init_pkg::done_ok,
                sd_init_pkg::done_error: begin
                    // cs_n rises one cycle after the result request
                    cs_n <= 1'b1;
                end
                default: begin
                    state <= sd_init_pkg::done_error;
                end
            endcase
        end
    end

    // led dark only after an error or timeout
    assign status_led = (state != sd_init_pkg::done_error);

endmodule

// File: debug_uart_tx.sv
/*
 * debug serial transmitter
 * sends one ASCII character per request as 8N1,
 * busy covers the whole frame
 */
`timescale 1ns/100ps

module debug_uart_tx #(
    parameter int BAUD_DIVISOR = 434
) (
    input  logic                     CLOCK_50,
    input  logic                     reset_n_sync,
    input  sd_init_pkg::debug_char_t dbg,
    output logic                     busy,
    output logic                     txd
);

    localparam int BAUD_W = $clog2(BAUD_DIVISOR + 1);

    // stop, data LSB first, start, shifted out from bit 0
    logic [9:0]        frame;
    logic [3:0]        bit_cnt;
    logic [BAUD_W-1:0] baud_cnt;

    always_ff @(posedge CLOCK_50 or negedge reset_n_sync) begin
        if (!reset_n_sync) begin
            busy     <= 1'b0;
            frame    <= '1;
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else if (dbg.valid && !busy) begin
            busy     <= 1'b1;
            frame    <= {1'b1, dbg.ch, 1'b0};
            bit_cnt  <= '0;
            baud_cnt <= BAUD_W'(BAUD_DIVISOR - 1);
        end else if (busy) begin
            if (baud_cnt == '0) begin
                // bit period over, next bit, line refills with idle ones
                baud_cnt <= BAUD_W'(BAUD_DIVISOR - 1);
                frame    <= {1'b1, frame[9:1]};
                bit_cnt  <= bit_cnt + 4'd1;
                // end of stop bit
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                end
            end else begin
                baud_cnt <= baud_cnt - 1'b1;
            end
        end
    end

    // line idles high
    assign txd = frame[0];

endmodule

// File: sd_init_top.sv
/*
 * SD card power-up top level
 * ties the CMD0 sequencer to the SPI byte master and the
 * debug transmitter, packs the card pins into one struct
 */
`timescale 1ns/100ps

module sd_init_top #(
    parameter int SCLK_HALF_CYCLES = 125,
    parameter int STARTUP_CYCLES   = 500000,
    parameter int BAUD_DIVISOR     = 434
) (
    input  logic                   CLOCK_50,
    input  logic                   reset_n_sync,
    input  logic                   miso,
    output sd_init_pkg::spi_pins_t spi,
    output logic                   uart_txd,
    output logic                   status_led
);

    // sequencer to SPI master strobes
    logic                     spi_start;
    sd_init_pkg::sd_byte_t    spi_tx;
    logic                     spi_ready;
    logic                     spi_done;
    sd_init_pkg::sd_byte_t    spi_rx;
    // card pins before packing
    logic                     sclk;
    logic                     mosi;
    logic                     cs_n;
    // debug character path
    sd_init_pkg::debug_char_t dbg;
    logic                     dbg_busy;

    sd_cmd0_sequencer #(
        .STARTUP_CYCLES(STARTUP_CYCLES)
    ) u_seq (
        .CLOCK_50     (CLOCK_50),
        .reset_n_sync (reset_n_sync),
        .spi_start    (spi_start),
        .spi_tx       (spi_tx),
        .spi_ready    (spi_ready),
        .spi_done     (spi_done),
        .spi_rx       (spi_rx),
        .cs_n         (cs_n),
        .dbg          (dbg),
        .dbg_busy     (dbg_busy),
        .status_led   (status_led)
    );

    spi_byte_master #(
        .SCLK_HALF_CYCLES(SCLK_HALF_CYCLES)
    ) u_spi (
        .CLOCK_50     (CLOCK_50),
        .reset_n_sync (reset_n_sync),
        .start        (spi_start),
        .tx_byte      (spi_tx),
        .ready        (spi_ready),
        .done         (spi_done),
        .rx_byte      (spi_rx),
        .sclk         (sclk),
        .mosi         (mosi),
        .miso         (miso)
    );

    debug_uart_tx #(
        .BAUD_DIVISOR(BAUD_DIVISOR)
    ) u_uart (
        .CLOCK_50     (CLOCK_50),
        .reset_n_sync (reset_n_sync),
        .dbg          (dbg),
        .busy         (dbg_busy),
        .txd          (uart_txd)
    );

    // cs_n from the sequencer, clock and data from the master
    assign spi = '{sclk: sclk, mosi: mosi, cs_n: cs_n};

endmodule

// File: sd_card_model.sv
/*
 * SD card model for the testbench
 * answers FILL_BYTE while polled, then one chosen R1 byte
 * after a chosen number of poll bytes, or never in timeout mode
 */
`timescale 1ns/100ps

module sd_card_model (
    input  sd_init_pkg::spi_pins_t spi,
    input  int                     poll_delay,
    input  sd_init_pkg::sd_byte_t  reply,
    input  logic                   timeout_mode,
    output logic                   miso
);

    int                    bit_cnt = 0;
    int                    byte_cnt = 0;
    sd_init_pkg::sd_byte_t out_sh;

    // byte the card puts out for a given poll index
    function automatic sd_init_pkg::sd_byte_t reply_byte(input int poll_idx);
        if (timeout_mode || poll_idx != poll_delay) begin
            return sd_init_pkg::FILL_BYTE;
        end
        return reply;
    endfunction

    // count bits and bytes on rising sclk
    // both counts restart while deselected
    always @(posedge spi.sclk) begin
        if (spi.cs_n) begin
            bit_cnt = 0;
            byte_cnt = 0;
        end else begin
            bit_cnt = (bit_cnt + 1) % 8;
            if (bit_cnt == 0) begin
                byte_cnt++;
            end
        end
    end

    // mode 0 puts the next bit out on the falling edge
    initial begin
        miso = 1'b1;
        forever begin
            @(negedge spi.sclk);
            if (spi.cs_n) begin
                // deselected card shifts out idle ones
                out_sh = sd_init_pkg::FILL_BYTE;
                miso = 1'b1;
            end else if (bit_cnt == 0) begin
                // poll index counts from the end of CMD0
                out_sh = reply_byte(byte_cnt - sd_init_pkg::CMD_LEN);
                miso = out_sh[7];
            end else begin
                out_sh = {out_sh[6:0], 1'b1};
                miso = out_sh[7];
            end
        end
    end

endmodule

// File: sd_init_sva.sv
/*
 * SPI byte master assertions
 * start/ready handshake, done width, idle sclk level
 */
`timescale 1ns/100ps

module sd_init_sva (
    input logic CLOCK_50,
    input logic reset_n_sync,
    input logic start,
    input logic ready,
    input logic done,
    input logic sclk
);

    // start only when the master is free
    start_when_ready: assert property (@(posedge CLOCK_50) disable iff (!reset_n_sync)
        start |-> ready) else $error("start given while SPI master busy");

    // done is a single cycle pulse
    done_one_cycle: assert property (@(posedge CLOCK_50) disable iff (!reset_n_sync)
        done |=> !done) else $error("done held longer than one cycle");

    // mode 0 idle level
    sclk_low_idle: assert property (@(posedge CLOCK_50) disable iff (!reset_n_sync)
        ready |-> !sclk) else $error("sclk high while SPI master idle");

endmodule

bind spi_byte_master sd_init_sva u_sva (.*);

// File: tb_sd_init.sv
/*
 * testbench for the SD card power-up top level
 * three runs with R1 idle reply, error reply and no reply,
 * with UART and SPI monitors and a result compare process
 */
`timescale 1ns/100ps

module tb_sd_init;

    localparam int SCLK_HALF_CYCLES = 2;
    localparam int STARTUP_CYCLES   = 16;
    localparam int BAUD_DIVISOR     = 8;
    // twice the length of 3 runs of startup, 130 bytes and 6 characters
    localparam int WATCHDOG_CYCLES  = 2 * 3 * (STARTUP_CYCLES + 130 * 16 * SCLK_HALF_CYCLES
                                      + 6 * 10 * BAUD_DIVISOR);
    localparam sd_init_pkg::spi_pins_t IDLE_PINS = '{sclk: 1'b0, mosi: 1'b1, cs_n: 1'b1};

    typedef struct packed {
        logic                  led;
        sd_init_pkg::sd_byte_t ch;
    } result_t;

    logic                   CLOCK_50 = 1'b0;
    logic                   reset_n_sync;
    logic                   miso;
    sd_init_pkg::spi_pins_t spi;
    logic                   uart_txd;
    logic                   status_led;

    // card model controls
    int                     poll_delay = 0;
    sd_init_pkg::sd_byte_t  card_reply = 8'h01;
    logic                   timeout_mode = 1'b0;
    logic [31:0]            lcg_state = 32'hd8ec;

    // monitor results
    sd_init_pkg::sd_byte_t  uart_q[$];
    sd_init_pkg::sd_byte_t  mosi_q[$];
    sd_init_pkg::sd_byte_t  mosi_sh;
    int                     mosi_bits = 0;
    int                     pon_edges = 0;
    event                   char_rx;

    sd_init_top #(
        .SCLK_HALF_CYCLES(SCLK_HALF_CYCLES),
        .STARTUP_CYCLES  (STARTUP_CYCLES),
        .BAUD_DIVISOR    (BAUD_DIVISOR)
    ) uut (
        .CLOCK_50     (CLOCK_50),
        .reset_n_sync (reset_n_sync),
        .miso         (miso),
        .spi          (spi),
        .uart_txd     (uart_txd),
        .status_led   (status_led)
    );

    sd_card_model card (
        .spi          (spi),
        .poll_delay   (poll_delay),
        .reply        (card_reply),
        .timeout_mode (timeout_mode),
        .miso         (miso)
    );

    always #20 CLOCK_50 = ~CLOCK_50;

    // ==============================
    // reference and compare tasks
    // ==============================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic result_t expected_result(input sd_init_pkg::sd_byte_t reply,
                                                input logic timeout);
        result_t r;
        r.led = 1'b0;
        r.ch  = sd_init_pkg::CHAR_ERROR;
        if (timeout) begin
            r.ch = sd_init_pkg::CHAR_TIMEOUT;
        end else if (reply == sd_init_pkg::R1_IDLE) begin
            r.led = 1'b1;
            r.ch  = sd_init_pkg::CHAR_OK;
        end
        return r;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_byte(input string name, input sd_init_pkg::sd_byte_t exp,
                              input sd_init_pkg::sd_byte_t got);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, got));
        end
    endtask

    task automatic check_pins(input string name, input sd_init_pkg::spi_pins_t exp,
                              input sd_init_pkg::spi_pins_t got);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, got));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, got));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        if (got != exp) begin
            stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, got));
        end
    endtask

    // ==============================
    // monitors
    // ==============================
    // uart decoder samples each bit mid-period
    always @(negedge uart_txd or negedge reset_n_sync) begin
        sd_init_pkg::sd_byte_t rx_ch;
        if (!reset_n_sync) begin
            uart_q.delete();
        end else begin
            repeat (BAUD_DIVISOR / 2) @(posedge CLOCK_50);
            check_bit("uart_txd start bit", 1'b0, uart_txd);
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD_DIVISOR) @(posedge CLOCK_50);
                rx_ch[i] = uart_txd;
            end
            repeat (BAUD_DIVISOR) @(posedge CLOCK_50);
            check_bit("uart_txd stop bit", 1'b1, uart_txd);
            uart_q.push_back(rx_ch);
            ->char_rx;
        end
    end

    // mosi bytes while cs_n is low and power-on edges while it is high
    always @(posedge spi.sclk or negedge reset_n_sync) begin
        if (!reset_n_sync) begin
            pon_edges = 0;
            mosi_bits = 0;
            mosi_q.delete();
        end else if (spi.cs_n) begin
            check_bit("mosi during power-on clocks", 1'b1, spi.mosi);
            pon_edges++;
        end else begin
            mosi_sh = {mosi_sh[6:0], spi.mosi};
            mosi_bits++;
            if (mosi_bits == 8) begin
                mosi_q.push_back(mosi_sh);
                mosi_bits = 0;
            end
        end
    end

    always @(negedge spi.cs_n) begin
        if (reset_n_sync) begin
            check_count("power-on sclk edges", sd_init_pkg::POWER_ON_BYTES * 8, pon_edges);
        end
    end

    // compare each debug character as it arrives
    always @(char_rx) begin
        int      idx;
        result_t exp;
        idx = uart_q.size() - 1;
        if (idx < sd_init_pkg::BANNER_LEN) begin
            check_byte("banner char", sd_init_pkg::BANNER[idx], uart_q[idx]);
        end else if (idx == sd_init_pkg::BANNER_LEN) begin
            exp = expected_result(card_reply, timeout_mode);
            check_byte("result char", exp.ch, uart_q[idx]);
            check_bit("cs_n after result", 1'b1, spi.cs_n);
            check_bit("status_led", exp.led, status_led);
        end else begin
            stop_with_failure("an extra debug character came after the result character");
        end
    end

    // ==============================
    // scenarios
    // ==============================
    task automatic check_reset_values();
        check_pins("spi", IDLE_PINS, spi);
        check_bit("uart_txd", 1'b1, uart_txd);
        check_bit("status_led", 1'b1, status_led);
    endtask

    task automatic run_scenario(input sd_init_pkg::sd_byte_t reply, input logic timeout);
        lcg_state    = lcg_next(lcg_state);
        poll_delay   = int'(lcg_state[23:16]) % 50;
        card_reply   = reply;
        timeout_mode = timeout;
        @(posedge CLOCK_50);
        reset_n_sync <= 1'b0;
        repeat (5) @(posedge CLOCK_50);
        check_reset_values();
        reset_n_sync <= 1'b1;
        // first clock edge with reset released has updated the outputs
        repeat (2) @(posedge CLOCK_50);
        check_reset_values();
        // the compare process checks banner and result as they arrive
        wait (uart_q.size() == sd_init_pkg::BANNER_LEN + 1);
        @(posedge CLOCK_50);
        for (int i = 0; i < sd_init_pkg::CMD_LEN; i++) begin
            check_byte("mosi CMD0 byte", sd_init_pkg::CMD0_FRAME[i], mosi_q[i]);
        end
        // card stays released
        repeat (20) begin
            @(posedge CLOCK_50);
            check_pins("spi after release", IDLE_PINS, spi);
        end
    endtask

    initial begin
        reset_n_sync = 1'b0;
        run_scenario(sd_init_pkg::R1_IDLE, 1'b0);
        run_scenario(8'h05, 1'b0);
        run_scenario(sd_init_pkg::FILL_BYTE, 1'b1);
        $display("TEST PASS");
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
        stop_with_failure("timeout, the runs did not finish in the allowed number of cycles");
    end

endmodule

// File: build.f
sd_init_pkg.sv
spi_byte_master.sv
sd_cmd0_sequencer.sv
debug_uart_tx.sv
sd_init_top.sv
sd_card_model.sv
sd_init_sva.sv
tb_sd_init.sv

// File: Makefile
TOP := tb_sd_init

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module sd_init_top sd_init_pkg.sv \
		spi_byte_master.sv sd_cmd0_sequencer.sv debug_uart_tx.sv sd_init_top.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
